/* list.f */
+incdir+logic
logic/ip_rx_pkg.sv
logic/ip_rx_ctrl.sv
logic/ip_hdr_capture.sv
logic/ip_csum_acc.sv
logic/ip_skid_buffer.sv
logic/ip_eth_rx.sv
verif/ip_eth_rx_properties.sv
verif/ip_eth_rx_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the ipv4 receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module ip_eth_rx_tb -Mdir build/obj

./build/obj/Vip_eth_rx_tb | tee build/sim.log

grep -q "^sim passed$" build/sim.log

/* verif/ip_eth_rx_tb.sv */
// testbench for the ipv4 frame receiver
// frame stimulus with xorshift back-pressure and gaps, expected header and
// payload queues, immediate checks on every transfer, error pulse and busy
`timescale 1ns/10ps
`include "ip_rx_macros.svh"

module ip_eth_rx_tb;
    import ip_rx_pkg::*;

    localparam int wait_limit = 2000;

    // bit positions in the error pulse vector
    localparam logic [3:0] err_hdr_early = 4'b1000;
    localparam logic [3:0] err_pay_early = 4'b0100;
    localparam logic [3:0] err_inv_hdr   = 4'b0010;
    localparam logic [3:0] err_inv_csum  = 4'b0001;

    logic       clk;
    logic       rst;
    logic       s_eth_hdr_valid;
    logic       s_eth_hdr_ready;
    byte_t      s_eth_payload_tdata;
    logic       s_eth_payload_tvalid;
    logic       s_eth_payload_tlast;
    logic       s_eth_payload_tready;
    logic       m_ip_hdr_valid;
    logic       m_ip_hdr_ready;
    logic [3:0] m_ip_version;
    logic [3:0] m_ip_ihl;
    word16_t    m_ip_length;
    byte_t      m_ip_protocol;
    ip_addr_t   m_ip_source_ip;
    ip_addr_t   m_ip_dest_ip;
    byte_t      m_ip_payload_tdata;
    logic       m_ip_payload_tvalid;
    logic       m_ip_payload_tlast;
    logic       m_ip_payload_tready;
    logic       busy;
    logic       error_header_early_termination;
    logic       error_payload_early_termination;
    logic       error_invalid_header;
    logic       error_invalid_checksum;

    // expected model
    logic [95:0] exp_hdr [$];
    logic [8:0]  exp_pay [$];
    logic [31:0] rng_state;
    // error flags carried by the byte on the input bus
    logic [3:0]  cur_err;
    logic [3:0]  err_due;
    logic        hdr_acc;
    logic        src_acc;
    // frame in progress between header accept and last byte
    logic        busy_exp;
    int          errors;
    int          hdr_count;
    int          byte_count;
    int          pulse_count;

    ip_eth_rx dut (.*);

    bind ip_eth_rx ip_eth_rx_properties u_properties (
        .clk                  (clk),
        .rst                  (rst),
        .s_eth_hdr_ready      (s_eth_hdr_ready),
        .s_eth_payload_tready (s_eth_payload_tready),
        .m_ip_hdr_valid       (m_ip_hdr_valid),
        .m_ip_hdr_ready       (m_ip_hdr_ready),
        .hdr_fields           ({m_ip_version, m_ip_ihl, m_ip_length, m_ip_protocol,
                                m_ip_source_ip, m_ip_dest_ip}),
        .m_ip_payload_tdata   (m_ip_payload_tdata),
        .m_ip_payload_tvalid  (m_ip_payload_tvalid),
        .m_ip_payload_tlast   (m_ip_payload_tlast),
        .m_ip_payload_tready  (m_ip_payload_tready),
        .busy                 (busy),
        .errors               ({error_header_early_termination,
                                error_payload_early_termination,
                                error_invalid_header, error_invalid_checksum})
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ones'-complement sum of the ten 16-bit header words
    function automatic word16_t ones_sum(input logic [159:0] hdr);
        logic [16:0] acc;
        acc = '0;
        for (int k = 0; k < 10; k++) begin
            acc = {1'b0, acc[15:0]} + {1'b0, hdr[159 - 16 * k -: 16]};
            acc = {1'b0, acc[15:0]} + {16'd0, acc[16]};
        end
        return acc[15:0];
    endfunction

    task automatic record_mismatch(input string msg);
        errors++;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("headers %0d, payload bytes %0d, error pulses %0d, errors %0d",
                 hdr_count, byte_count, pulse_count, errors);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        finish_run(1'b1);
    endtask

    // outputs are registered, inputs were set at this falling edge,
    // so these are the transfers of the coming rising edge
    task automatic check_transfers();
        logic [3:0] errs;
        errs = {error_header_early_termination, error_payload_early_termination,
                error_invalid_header, error_invalid_checksum};
        if (!rst) begin
            assert (busy == busy_exp)
            else record_mismatch($sformatf("busy %b, expected %b", busy, busy_exp));
            assert (errs == err_due)
            else record_mismatch($sformatf("error pulses %b, expected %b", errs, err_due));
            if (errs != 4'b0) pulse_count++;
            if (m_ip_hdr_valid && m_ip_hdr_ready) begin
                hdr_count++;
                assert (exp_hdr.size() > 0)
                else record_mismatch("header valid with no header expected");
                if (exp_hdr.size() > 0) begin
                    assert ({m_ip_version, m_ip_ihl, m_ip_length, m_ip_protocol,
                             m_ip_source_ip, m_ip_dest_ip} == exp_hdr[0])
                    else record_mismatch($sformatf("header fields, expected %h", exp_hdr[0]));
                    void'(exp_hdr.pop_front());
                end
            end
            if (m_ip_payload_tvalid && m_ip_payload_tready) begin
                byte_count++;
                assert (exp_pay.size() > 0)
                else record_mismatch("payload byte with no byte expected");
                if (exp_pay.size() > 0) begin
                    assert ({m_ip_payload_tlast, m_ip_payload_tdata} == exp_pay[0])
                    else record_mismatch($sformatf("payload last/data %b/%h, expected %h",
                                         m_ip_payload_tlast, m_ip_payload_tdata, exp_pay[0]));
                    void'(exp_pay.pop_front());
                end
            end
        end
        hdr_acc = !rst && s_eth_hdr_valid && s_eth_hdr_ready;
        src_acc = !rst && s_eth_payload_tvalid && s_eth_payload_tready;
        err_due = src_acc ? cur_err : 4'b0;
        // busy rises after the header accept and falls after the last byte
        if (hdr_acc) begin
            busy_exp = 1'b1;
        end else if (src_acc && s_eth_payload_tlast) begin
            busy_exp = 1'b0;
        end
    endtask

    task automatic step_cycle();
        logic [31:0] r;
        check_transfers();
        @(negedge clk);
        r = next_rand();
        m_ip_payload_tready = r[0] | r[1];
        m_ip_hdr_ready      = r[2];
    endtask

    // ethernet header strobe, then hdr_len ip header bytes and pay_len payload bytes
    task automatic send_frame(input logic [3:0] ver, input logic [3:0] ihl,
                              input word16_t length, input int pay_len,
                              input bit bad_csum, input int hdr_len);
        logic [159:0] hdr;
        byte_t        data [$];
        logic [3:0]   errs [$];
        word16_t      csum;
        logic [31:0]  r;
        int           waited;
        r = next_rand();
        hdr[159:64] = {ver, ihl, r[7:0], length, r[31:16], 16'h4000, 8'd64, r[15:8], 16'h0000};
        hdr[63:32]  = next_rand();
        hdr[31:0]   = next_rand();
        csum = ~ones_sum(hdr);
        if (bad_csum) csum = csum ^ 16'h0001;
        hdr[79:64] = csum;
        for (int i = 0; i < hdr_len; i++) begin
            data.push_back(hdr[159 - 8 * i -: 8]);
            errs.push_back(4'b0);
        end
        for (int i = 0; i < pay_len; i++) begin
            r = next_rand();
            data.push_back(r[7:0]);
            errs.push_back(4'b0);
        end
        if (hdr_len < `IP_HDR_BYTES) begin
            errs[hdr_len - 1] = err_hdr_early;
        end else if (ver != `IP_VERSION || ihl != `IP_IHL) begin
            errs[`IP_HDR_BYTES - 1] = err_inv_hdr;
        end else if (bad_csum) begin
            errs[`IP_HDR_BYTES - 1] = err_inv_csum;
        end else begin
            exp_hdr.push_back({ver, ihl, length, hdr[87:80], hdr[63:32], hdr[31:0]});
            for (int i = `IP_HDR_BYTES; i < data.size(); i++) begin
                exp_pay.push_back({i == data.size() - 1, data[i]});
            end
            // short payload flagged on its last byte
            if (pay_len < int'(length) - `IP_HDR_BYTES) errs[errs.size() - 1] = err_pay_early;
        end

        s_eth_hdr_valid = 1'b1;
        waited = 0;
        do begin
            step_cycle();
            waited++;
        end while (!hdr_acc && waited < wait_limit);
        s_eth_hdr_valid = 1'b0;
        if (!hdr_acc) abort_on_timeout("ethernet header accept");

        foreach (data[i]) begin
            r = next_rand();
            if (r[1:0] == 2'b00) begin
                s_eth_payload_tvalid = 1'b0;
                cur_err              = 4'b0;
                step_cycle();
            end
            s_eth_payload_tdata  = data[i];
            s_eth_payload_tlast  = i == data.size() - 1;
            s_eth_payload_tvalid = 1'b1;
            cur_err              = errs[i];
            waited = 0;
            do begin
                step_cycle();
                waited++;
            end while (!src_acc && waited < wait_limit);
            if (!src_acc) abort_on_timeout("payload byte accept");
        end
        s_eth_payload_tvalid = 1'b0;
        s_eth_payload_tlast  = 1'b0;
        cur_err              = 4'b0;
    endtask

    initial begin
        int waited;
        rst                  = 1'b1;
        s_eth_hdr_valid      = 1'b0;
        s_eth_payload_tdata  = 8'h00;
        s_eth_payload_tvalid = 1'b0;
        s_eth_payload_tlast  = 1'b0;
        m_ip_hdr_ready       = 1'b0;
        m_ip_payload_tready  = 1'b0;
        rng_state            = 32'hffc9_50c5;
        cur_err              = 4'b0;
        err_due              = 4'b0;
        hdr_acc              = 1'b0;
        src_acc              = 1'b0;
        busy_exp             = 1'b0;
        errors               = 0;
        hdr_count            = 0;
        byte_count           = 0;
        pulse_count          = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send_frame(`IP_VERSION, `IP_IHL, 16'd28, 8, 1'b0, `IP_HDR_BYTES);
        send_frame(`IP_VERSION, `IP_IHL, 16'd50, 30, 1'b0, `IP_HDR_BYTES);
        // corrupted checksum, then a normal frame
        send_frame(`IP_VERSION, `IP_IHL, 16'd25, 5, 1'b1, `IP_HDR_BYTES);
        send_frame(`IP_VERSION, `IP_IHL, 16'd23, 3, 1'b0, `IP_HDR_BYTES);
        // bad version, bad IHL, bad version with bad checksum
        send_frame(4'd6, `IP_IHL, 16'd24, 4, 1'b0, `IP_HDR_BYTES);
        send_frame(`IP_VERSION, 4'd6, 16'd24, 4, 1'b0, `IP_HDR_BYTES);
        send_frame(4'd6, `IP_IHL, 16'd24, 4, 1'b1, `IP_HDR_BYTES);
        send_frame(`IP_VERSION, `IP_IHL, 16'd30, 10, 1'b0, `IP_HDR_BYTES);
        // frame ends inside the ip header
        send_frame(`IP_VERSION, `IP_IHL, 16'd40, 0, 1'b0, 12);
        send_frame(`IP_VERSION, `IP_IHL, 16'd21, 1, 1'b0, `IP_HDR_BYTES);
        // payload shorter than the length field, then longer
        send_frame(`IP_VERSION, `IP_IHL, 16'd40, 6, 1'b0, `IP_HDR_BYTES);
        send_frame(`IP_VERSION, `IP_IHL, 16'd24, 7, 1'b0, `IP_HDR_BYTES);
        send_frame(`IP_VERSION, `IP_IHL, 16'd36, 16, 1'b0, `IP_HDR_BYTES);

        repeat (3) step_cycle();
        waited = 0;
        while ((exp_hdr.size() != 0 || exp_pay.size() != 0) && waited < wait_limit) begin
            step_cycle();
            waited++;
        end
        if (exp_hdr.size() != 0 || exp_pay.size() != 0) begin
            $display("expected headers or payload bytes were never delivered");
            errors++;
        end
        finish_run(1'b0);
    end

endmodule

/* verif/ip_eth_rx_properties.sv */
// concurrent checks on the ipv4 receiver ports
// idle outputs after reset, payload and header hold under back-pressure,
// error pulse shape
`timescale 1ns/10ps

module ip_eth_rx_properties (
    input logic        clk,
    input logic        rst,
    input logic        s_eth_hdr_ready,
    input logic        s_eth_payload_tready,
    input logic        m_ip_hdr_valid,
    input logic        m_ip_hdr_ready,
    input logic [95:0] hdr_fields,
    input logic [7:0]  m_ip_payload_tdata,
    input logic        m_ip_payload_tvalid,
    input logic        m_ip_payload_tlast,
    input logic        m_ip_payload_tready,
    input logic        busy,
    input logic [3:0]  errors
);

    // nothing pending in the cycle after a reset cycle
    reset_idle: assert property (@(posedge clk)
        rst |=> !s_eth_hdr_ready && !s_eth_payload_tready && !m_ip_hdr_valid
            && !m_ip_payload_tvalid && !busy && errors == 4'b0)
    else $error("outputs not idle after reset");

    // stalled payload byte stays on the bus
    payload_hold: assert property (@(posedge clk) disable iff (rst)
        m_ip_payload_tvalid && !m_ip_payload_tready |=>
            m_ip_payload_tvalid && $stable(m_ip_payload_tdata) && $stable(m_ip_payload_tlast))
    else $error("payload output changed while stalled");

    header_hold: assert property (@(posedge clk) disable iff (rst)
        m_ip_hdr_valid && !m_ip_hdr_ready |=> m_ip_hdr_valid && $stable(hdr_fields))
    else $error("header valid dropped or fields changed before ready");

    error_pulse: assert property (@(posedge clk) disable iff (rst)
        errors != 4'b0 |=> errors == 4'b0)
    else $error("error output high for more than one cycle");

    error_single: assert property (@(posedge clk) disable iff (rst) $onehot0(errors))
    else $error("more than one error output high");

endmodule

/* logic/ip_eth_rx.sv */
// ipv4 frame receiver top level
// ethernet header strobe and payload stream in, decoded ip header
// and ip payload stream out
`timescale 1ns/10ps

module ip_eth_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                s_eth_hdr_valid,
    output logic                s_eth_hdr_ready,
    input  ip_rx_pkg::byte_t    s_eth_payload_tdata,
    input  logic                s_eth_payload_tvalid,
    input  logic                s_eth_payload_tlast,
    output logic                s_eth_payload_tready,
    output logic                m_ip_hdr_valid,
    input  logic                m_ip_hdr_ready,
    output logic [3:0]          m_ip_version,
    output logic [3:0]          m_ip_ihl,
    output ip_rx_pkg::word16_t  m_ip_length,
    output ip_rx_pkg::byte_t    m_ip_protocol,
    output ip_rx_pkg::ip_addr_t m_ip_source_ip,
    output ip_rx_pkg::ip_addr_t m_ip_dest_ip,
    output ip_rx_pkg::byte_t    m_ip_payload_tdata,
    output logic                m_ip_payload_tvalid,
    output logic                m_ip_payload_tlast,
    input  logic                m_ip_payload_tready,
    output logic                busy,
    output logic                error_header_early_termination,
    output logic                error_payload_early_termination,
    output logic                error_invalid_header,
    output logic                error_invalid_checksum
);
    import ip_rx_pkg::*;

    logic     capture_en;
    hdr_ptr_t hdr_ptr;
    logic     sum_clear;
    logic     sum_add;
    word16_t  sum_next;
    logic     pay_valid;
    logic     pay_last;
    logic     pay_ready_early;

    ip_rx_ctrl u_ctrl (
        .clk                             (clk),
        .rst                             (rst),
        .s_eth_hdr_valid                 (s_eth_hdr_valid),
        .s_eth_hdr_ready                 (s_eth_hdr_ready),
        .s_eth_payload_tvalid            (s_eth_payload_tvalid),
        .s_eth_payload_tlast             (s_eth_payload_tlast),
        .s_eth_payload_tready            (s_eth_payload_tready),
        .m_ip_hdr_ready                  (m_ip_hdr_ready),
        .m_ip_hdr_valid                  (m_ip_hdr_valid),
        .hdr_version                     (m_ip_version),
        .hdr_ihl                         (m_ip_ihl),
        .hdr_length                      (m_ip_length),
        .sum_next                        (sum_next),
        .capture_en                      (capture_en),
        .hdr_ptr                         (hdr_ptr),
        .sum_clear                       (sum_clear),
        .sum_add                         (sum_add),
        .pay_valid                       (pay_valid),
        .pay_last                        (pay_last),
        .pay_ready_early                 (pay_ready_early),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination),
        .error_invalid_header            (error_invalid_header),
        .error_invalid_checksum          (error_invalid_checksum)
    );

    ip_hdr_capture u_capture (
        .clk        (clk),
        .capture_en (capture_en),
        .hdr_ptr    (hdr_ptr),
        .data       (s_eth_payload_tdata),
        .version    (m_ip_version),
        .ihl        (m_ip_ihl),
        .length     (m_ip_length),
        .protocol   (m_ip_protocol),
        .source_ip  (m_ip_source_ip),
        .dest_ip    (m_ip_dest_ip)
    );

    ip_csum_acc u_csum (
        .clk         (clk),
        .sum_clear   (sum_clear),
        .sum_add     (sum_add),
        .hdr_ptr_lsb (hdr_ptr[0]),
        .data        (s_eth_payload_tdata),
        .sum_next    (sum_next)
    );

    ip_skid_buffer u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_data     (s_eth_payload_tdata),
        .in_valid    (pay_valid),
        .in_last     (pay_last),
        .ready_early (pay_ready_early),
        .out_data    (m_ip_payload_tdata),
        .out_valid   (m_ip_payload_tvalid),
        .out_last    (m_ip_payload_tlast),
        .out_ready   (m_ip_payload_tready)
    );

endmodule

/* logic/ip_skid_buffer.sv */
// payload output stage
// registered output with one skid register, early ready to the source
`timescale 1ns/10ps

module ip_skid_buffer (
    input  logic             clk,
    input  logic             rst,
    input  ip_rx_pkg::byte_t in_data,
    input  logic             in_valid,
    input  logic             in_last,
    output logic             ready_early,
    output ip_rx_pkg::byte_t out_data,
    output logic             out_valid,
    output logic             out_last,
    input  logic             out_ready
);
    import ip_rx_pkg::*;

    byte_t out_data_q;
    byte_t skid_data_q;
    logic  out_last_q;
    logic  skid_last_q;
    logic  out_valid_q, out_valid_d;
    logic  skid_valid_q, skid_valid_d;
    logic  in_ready_q;

    logic load_out_from_in;
    logic load_skid;
    logic load_out_from_skid;

    // ready next cycle unless the skid register would have to fill
    assign ready_early = out_ready || (!skid_valid_q && (!out_valid_q || !in_valid));

    always_comb begin
        out_valid_d        = out_valid_q;
        skid_valid_d       = skid_valid_q;
        load_out_from_in   = 1'b0;
        load_skid          = 1'b0;
        load_out_from_skid = 1'b0;

        if (in_ready_q) begin
            if (out_ready || !out_valid_q) begin
                out_valid_d      = in_valid;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park the byte
                skid_valid_d = in_valid;
                load_skid    = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_d        = skid_valid_q;
            skid_valid_d       = 1'b0;
            load_out_from_skid = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b0;
        end else begin
            out_valid_q  <= out_valid_d;
            skid_valid_q <= skid_valid_d;
            in_ready_q   <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_data_q <= in_data;
            out_last_q <= in_last;
        end else if (load_out_from_skid) begin
            out_data_q <= skid_data_q;
            out_last_q <= skid_last_q;
        end
        if (load_skid) begin
            skid_data_q <= in_data;
            skid_last_q <= in_last;
        end
    end

    assign out_data  = out_data_q;
    assign out_valid = out_valid_q;
    assign out_last  = out_last_q;

endmodule

/* logic/ip_csum_acc.sv */
// ip header checksum accumulator
// 16-bit ones'-complement sum, one byte per accepted header byte,
// updated sum exposed before the register
`timescale 1ns/10ps

module ip_csum_acc (
    input  logic               clk,
    input  logic               sum_clear,
    input  logic               sum_add,
    input  logic               hdr_ptr_lsb,
    input  ip_rx_pkg::byte_t   data,
    output ip_rx_pkg::word16_t sum_next
);
    import ip_rx_pkg::*;

    word16_t     sum_q;
    word16_t     addend;
    logic [16:0] raw_sum;

    // even bytes are the high half of a header word
    assign addend = hdr_ptr_lsb ? {8'h00, data} : {data, 8'h00};

    // end-around carry
    assign raw_sum  = {1'b0, sum_q} + {1'b0, addend};
    assign sum_next = raw_sum[15:0] + {15'd0, raw_sum[16]};

    always_ff @(posedge clk) begin
        if (sum_clear) begin
            sum_q <= '0;
        end else if (sum_add) begin
            sum_q <= sum_next;
        end
    end

endmodule

/* logic/ip_hdr_capture.sv */
// ip header field capture
// per-byte load of version/IHL, length, protocol and both addresses,
// multi-byte fields most significant byte first
`timescale 1ns/10ps

module ip_hdr_capture (
    input  logic                clk,
    input  logic                capture_en,
    input  ip_rx_pkg::hdr_ptr_t hdr_ptr,
    input  ip_rx_pkg::byte_t    data,
    output logic [3:0]          version,
    output logic [3:0]          ihl,
    output ip_rx_pkg::word16_t  length,
    output ip_rx_pkg::byte_t    protocol,
    output ip_rx_pkg::ip_addr_t source_ip,
    output ip_rx_pkg::ip_addr_t dest_ip
);
    import ip_rx_pkg::*;

    // first header byte holds version and IHL
    byte_t ver_ihl_q;

    always_ff @(posedge clk) begin
        if (capture_en) begin
            unique case (hdr_ptr)
                hdr_ptr_t'(0):  ver_ihl_q        <= data;
                hdr_ptr_t'(2):  length[15:8]     <= data;
                hdr_ptr_t'(3):  length[7:0]      <= data;
                hdr_ptr_t'(9):  protocol         <= data;
                hdr_ptr_t'(12): source_ip[31:24] <= data;
                hdr_ptr_t'(13): source_ip[23:16] <= data;
                hdr_ptr_t'(14): source_ip[15:8]  <= data;
                hdr_ptr_t'(15): source_ip[7:0]   <= data;
                hdr_ptr_t'(16): dest_ip[31:24]   <= data;
                hdr_ptr_t'(17): dest_ip[23:16]   <= data;
                hdr_ptr_t'(18): dest_ip[15:8]    <= data;
                hdr_ptr_t'(19): dest_ip[7:0]     <= data;
                // tos, id, flags, ttl and checksum bytes are not kept
                default: begin
                end
            endcase
        end
    end

    assign version = ver_ihl_q[7:4];
    assign ihl     = ver_ihl_q[3:0];

endmodule

/* logic/ip_rx_ctrl.sv */
// frame sequencing FSM for the ipv4 receiver
// header byte pointer, payload byte counter, header checks,
// header valid handshake, busy and error pulses
`timescale 1ns/10ps
`include "ip_rx_macros.svh"

module ip_rx_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                s_eth_hdr_valid,
    output logic                s_eth_hdr_ready,
    input  logic                s_eth_payload_tvalid,
    input  logic                s_eth_payload_tlast,
    output logic                s_eth_payload_tready,
    input  logic                m_ip_hdr_ready,
    output logic                m_ip_hdr_valid,
    input  logic [3:0]          hdr_version,
    input  logic [3:0]          hdr_ihl,
    input  ip_rx_pkg::word16_t  hdr_length,
    input  ip_rx_pkg::word16_t  sum_next,
    output logic                capture_en,
    output ip_rx_pkg::hdr_ptr_t hdr_ptr,
    output logic                sum_clear,
    output logic                sum_add,
    output logic                pay_valid,
    output logic                pay_last,
    input  logic                pay_ready_early,
    output logic                busy,
    output logic                error_header_early_termination,
    output logic                error_payload_early_termination,
    output logic                error_invalid_header,
    output logic                error_invalid_checksum
);
    import ip_rx_pkg::*;

    rx_state_t state_q, state_d;
    hdr_ptr_t  hdr_ptr_q, hdr_ptr_d;
    word16_t   pay_count_q, pay_count_d;

    logic hdr_ready_q, hdr_ready_d;
    logic pay_ready_q, pay_ready_d;
    logic hdr_valid_q, hdr_valid_d;
    logic busy_q;
    logic err_hdr_early_q, err_hdr_early_d;
    logic err_pay_early_q, err_pay_early_d;
    logic err_inv_hdr_q, err_inv_hdr_d;
    logic err_inv_csum_q, err_inv_csum_d;

    logic hdr_accept;
    logic pay_accept;
    logic hdr_last;

    assign hdr_accept = hdr_ready_q && s_eth_hdr_valid;
    assign pay_accept = pay_ready_q && s_eth_payload_tvalid;
    assign hdr_last   = hdr_ptr_q == hdr_ptr_t'(`IP_HDR_BYTES - 1);

    // datapath strobes
    assign capture_en = (state_q == st_read_header) && pay_accept;
    assign sum_add    = capture_en;
    assign sum_clear  = state_q == st_idle;
    assign hdr_ptr    = hdr_ptr_q;
    assign pay_valid  = (state_q == st_read_payload) && pay_accept;
    assign pay_last   = s_eth_payload_tlast;

    always_comb begin
        state_d         = state_q;
        hdr_ptr_d       = hdr_ptr_q;
        pay_count_d     = pay_count_q;
        hdr_ready_d     = 1'b0;
        pay_ready_d     = 1'b0;
        hdr_valid_d     = hdr_valid_q && !m_ip_hdr_ready;
        err_hdr_early_d = 1'b0;
        err_pay_early_d = 1'b0;
        err_inv_hdr_d   = 1'b0;
        err_inv_csum_d  = 1'b0;

        unique case (state_q)
            st_idle: begin
                hdr_ptr_d   = '0;
                // no new frame while the last header is still pending
                hdr_ready_d = !hdr_valid_d;
                if (hdr_accept) begin
                    hdr_ready_d = 1'b0;
                    pay_ready_d = 1'b1;
                    state_d     = st_read_header;
                end
            end
            st_read_header: begin
                pay_ready_d = 1'b1;
                if (pay_accept) begin
                    hdr_ptr_d = hdr_ptr_q + hdr_ptr_t'(1);
                    if (hdr_last) begin
                        pay_count_d = hdr_length - word16_t'(`IP_HDR_BYTES);
                        if (hdr_version != `IP_VERSION || hdr_ihl != `IP_IHL) begin
                            err_inv_hdr_d = 1'b1;
                            state_d       = st_wait_last;
                        end else if (sum_next != `IP_CSUM_OK) begin
                            err_inv_csum_d = 1'b1;
                            state_d        = st_wait_last;
                        end else begin
                            hdr_valid_d = 1'b1;
                            pay_ready_d = pay_ready_early;
                            state_d     = st_read_payload;
                        end
                    end
                    // frame ended inside the header
                    if (s_eth_payload_tlast) begin
                        err_hdr_early_d = 1'b1;
                        err_inv_hdr_d   = 1'b0;
                        err_inv_csum_d  = 1'b0;
                        hdr_valid_d     = 1'b0;
                        hdr_ready_d     = !hdr_valid_d;
                        pay_ready_d     = 1'b0;
                        state_d         = st_idle;
                    end
                end
            end
            st_read_payload: begin
                pay_ready_d = pay_ready_early;
                if (pay_accept) begin
                    // bytes past the ip length run through, count stops at zero
                    if (pay_count_q != '0) begin
                        pay_count_d = pay_count_q - word16_t'(1);
                    end
                    if (s_eth_payload_tlast) begin
                        if (pay_count_q > word16_t'(1)) begin
                            err_pay_early_d = 1'b1;
                        end
                        hdr_ready_d = !hdr_valid_d;
                        pay_ready_d = 1'b0;
                        state_d     = st_idle;
                    end
                end
            end
            st_wait_last: begin
                // drop the rest of a rejected frame
                pay_ready_d = 1'b1;
                if (pay_accept && s_eth_payload_tlast) begin
                    hdr_ready_d = !hdr_valid_d;
                    pay_ready_d = 1'b0;
                    state_d     = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= st_idle;
            hdr_ptr_q       <= '0;
            pay_count_q     <= '0;
            hdr_ready_q     <= 1'b0;
            pay_ready_q     <= 1'b0;
            hdr_valid_q     <= 1'b0;
            busy_q          <= 1'b0;
            err_hdr_early_q <= 1'b0;
            err_pay_early_q <= 1'b0;
            err_inv_hdr_q   <= 1'b0;
            err_inv_csum_q  <= 1'b0;
        end else begin
            state_q         <= state_d;
            hdr_ptr_q       <= hdr_ptr_d;
            pay_count_q     <= pay_count_d;
            hdr_ready_q     <= hdr_ready_d;
            pay_ready_q     <= pay_ready_d;
            hdr_valid_q     <= hdr_valid_d;
            busy_q          <= state_d != st_idle;
            err_hdr_early_q <= err_hdr_early_d;
            err_pay_early_q <= err_pay_early_d;
            err_inv_hdr_q   <= err_inv_hdr_d;
            err_inv_csum_q  <= err_inv_csum_d;
        end
    end

    assign s_eth_hdr_ready                 = hdr_ready_q;
    assign s_eth_payload_tready            = pay_ready_q;
    assign m_ip_hdr_valid                  = hdr_valid_q;
    assign busy                            = busy_q;
    assign error_header_early_termination  = err_hdr_early_q;
    assign error_payload_early_termination = err_pay_early_q;
    assign error_invalid_header            = err_inv_hdr_q;
    assign error_invalid_checksum          = err_inv_csum_q;

endmodule

/* logic/ip_rx_pkg.sv */
// shared types for the ipv4 receiver
// stream byte, 16-bit word, address, header pointer, FSM state
`include "ip_rx_macros.svh"

package ip_rx_pkg;

    // one byte of the payload stream
    typedef logic [7:0] byte_t;

    // length, checksum and payload count
    typedef logic [15:0] word16_t;

    typedef logic [31:0] ip_addr_t;

    // index of the current ip header byte
    typedef logic [`IP_PTR_W-1:0] hdr_ptr_t;

    // frame sequencing states
    typedef enum logic [1:0] {
        st_idle,
        st_read_header,
        st_read_payload,
        st_wait_last
    } rx_state_t;

endpackage

/* logic/ip_rx_macros.svh */
// widths and protocol constants for the ipv4 receiver
// header length, accepted version and IHL, checksum target
`ifndef IP_RX_MACROS_SVH
`define IP_RX_MACROS_SVH

// ip header without options, in bytes
`define IP_HDR_BYTES 20

// only plain ipv4 with a 5-word header is accepted
`define IP_VERSION 4'd4
`define IP_IHL 4'd5

// ones'-complement sum over a valid header
`define IP_CSUM_OK 16'hffff

// header byte pointer width
`define IP_PTR_W 5

`endif
